/* tcdm_pkg.sv */
// memory-side constants of the load streamer, referenced by package scope from RTL and testbench
`default_nettype none

package tcdm_pkg;

  // number of parallel word ports toward the data memory
  // all ports request together and see one shared grant decision
  localparam int unsigned NB_PORTS = 2;

  // one memory word per port and access
  localparam int unsigned WORD_W = 32;

  // byte address on the memory bus
  localparam int unsigned ADDR_W = 32;

  // address distance between neighbouring ports
  localparam int unsigned WORD_BYTES = WORD_W / 8;  // 4 bytes per word

  // memory timing seen by the streamer:
  //   req & gnt        -> read accepted
  //   one cycle later  -> r_valid with r_data
  // the memory is read only, no write channel exists

endpackage : tcdm_pkg

`default_nettype wire

/* streamer_pkg.sv */
// streamer-side constants and controller state type, referenced by package scope in every module
`default_nettype none

package streamer_pkg;

  // width of transfer size, line length and line stride counters
  // a transfer overflows at 2**CNT_W beats
  localparam int unsigned CNT_W = 16;

  // one stream beat carries a word from every port, port 0 in the low bits
  localparam int unsigned STREAM_W = tcdm_pkg::NB_PORTS * tcdm_pkg::WORD_W;

  // address advance per beat inside a line
  localparam int unsigned STEP_BYTES = tcdm_pkg::NB_PORTS * tcdm_pkg::WORD_BYTES;

  // controller FSM
  //   ST_IDLE     waiting for a start request, ready_start high
  //   ST_WORKING  issuing reads, one per beat, while the stream is ready
  typedef enum logic [0:0] {
    ST_IDLE    = 1'b0,
    ST_WORKING = 1'b1
  } state_e;

endpackage : streamer_pkg

`default_nettype wire

/* source_addressgen.sv */
// two-dimensional read address generator, stepped once per accepted memory request by the controller
`timescale 1ns/10ps
`default_nettype none

module source_addressgen (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,       // restart pattern at beat 0
  input  logic                              enable_i,      // advance to next beat
  input  logic [tcdm_pkg::ADDR_W-1:0]       base_addr_i,
  input  logic [streamer_pkg::CNT_W-1:0]    trans_size_i,  // beats in the transfer
  input  logic [streamer_pkg::CNT_W-1:0]    line_length_i, // beats per line
  input  logic [streamer_pkg::CNT_W-1:0]    line_stride_i, // bytes between line starts
  output logic [tcdm_pkg::ADDR_W-1:0]       addr_o,        // address of current beat
  output logic                              in_progress_o  // low on the final beat
);

  logic [streamer_pkg::CNT_W-1:0] beat_q;     // beats already issued
  logic [streamer_pkg::CNT_W-1:0] col_q;      // column inside current line
  logic [tcdm_pkg::ADDR_W-1:0]    col_off_q;  // byte offset of column in line
  logic [tcdm_pkg::ADDR_W-1:0]    line_off_q; // byte offset of current line start
  logic                           line_end;   // current beat closes its line
  logic [streamer_pkg::CNT_W:0]   beat_next;  // one extra bit, no wrap on compare
  logic [streamer_pkg::CNT_W:0]   size_ext;

  assign line_end = (col_q == line_length_i - 1'b1);

  // beat_q + 1 < trans_size, i.e. beat_q below trans_size - 1
  assign beat_next     = {1'b0, beat_q} + 1'b1;
  assign size_ext      = {1'b0, trans_size_i};
  assign in_progress_o = (beat_next < size_ext);

  // base stays stable during a transfer, only the offsets are registered
  assign addr_o = base_addr_i + line_off_q + col_off_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q     <= '0;
      col_q      <= '0;
      col_off_q  <= '0;
      line_off_q <= '0;
    end else if (clear_i) begin
      beat_q     <= '0;
      col_q      <= '0;
      col_off_q  <= '0;
      line_off_q <= '0;
    end else if (enable_i) begin
      beat_q <= beat_q + 1'b1;
      if (line_end) begin
        // wrap to column 0 of the next line
        col_q      <= '0;
        col_off_q  <= '0;
        line_off_q <= line_off_q + (tcdm_pkg::ADDR_W)'(line_stride_i);
      end else begin
        col_q     <= col_q + 1'b1;
        col_off_q <= col_off_q + (tcdm_pkg::ADDR_W)'(streamer_pkg::STEP_BYTES);
      end
    end
  end

  // controller must not step past the final beat, it clears instead
  a_no_step_past_end: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> in_progress_o
  ) else $error("address generator stepped past the final beat");

endmodule : source_addressgen

`default_nettype wire

/* source_ctrl.sv */
// controller FSM of the load streamer, gates memory requests on stream ready and flags the end
`timescale 1ns/10ps
`default_nettype none

module source_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          req_start_i,    // host start, taken in idle only
  input  logic                          stream_ready_i, // sink ready for the output stream
  input  logic [tcdm_pkg::NB_PORTS-1:0] tcdm_gnt_i,
  input  logic                          in_progress_i,  // from address generator
  output logic [tcdm_pkg::NB_PORTS-1:0] tcdm_req_o,
  output logic                          gen_en_o,       // step address generator
  output logic                          gen_clr_o,      // restart address generator
  output logic                          ready_start_o,
  output logic                          done_o
);

  streamer_pkg::state_e state_q;
  streamer_pkg::state_e state_d;

  logic int_req;   // common request of all ports
  logic int_gnt;   // combined grant
  logic accept;    // read accepted on all ports
  logic last_beat; // final read of the transfer accepted
  logic done_q;

  // grants arrive together, the AND is the agreed decision
  assign int_gnt = &tcdm_gnt_i;

  // request only while the sink can take the response next cycle,
  // so at most one word per port is ever waiting in the holds
  assign int_req = (state_q == streamer_pkg::ST_WORKING) & stream_ready_i & ~clear_i;

  assign tcdm_req_o = {tcdm_pkg::NB_PORTS{int_req}};

  assign accept    = int_req & int_gnt;
  assign gen_en_o  = accept & in_progress_i;  // step unless this was the final beat
  assign last_beat = accept & ~in_progress_i;
  assign gen_clr_o = clear_i | last_beat;     // back to beat 0 for the next start

  assign ready_start_o = (state_q == streamer_pkg::ST_IDLE);
  assign done_o        = done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      streamer_pkg::ST_IDLE: begin
        if (req_start_i) begin
          state_d = streamer_pkg::ST_WORKING;
        end
      end
      streamer_pkg::ST_WORKING: begin
        if (last_beat) begin
          state_d = streamer_pkg::ST_IDLE;  // last response still in flight
        end
      end
      default: begin
        state_d = streamer_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= streamer_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= streamer_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= last_beat;  // lines up with the final response
    end
  end

  // memory must grant all ports or none while requesting
  a_gnt_agree: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    int_req |-> ((tcdm_gnt_i == '0) || (&tcdm_gnt_i))
  ) else $error("memory ports granted inconsistently");

endmodule : source_ctrl

`default_nettype wire

/* source_resp_hold.sv */
// per-port read response buffer that passes a word through and holds it while the stream stalls
`timescale 1ns/10ps
`default_nettype none

module source_resp_hold (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        r_valid_i, // memory response valid
  input  logic [tcdm_pkg::WORD_W-1:0] r_data_i,
  input  logic                        ready_i,   // beat taken by the merge
  output logic                        valid_o,
  output logic [tcdm_pkg::WORD_W-1:0] data_o
);

  logic                        valid_q; // word captured and not yet taken
  logic [tcdm_pkg::WORD_W-1:0] data_q;

  // fresh response has priority for zero latency when ready
  assign valid_o = r_valid_i | valid_q;
  assign data_o  = r_valid_i ? r_data_i : data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (r_valid_i & ~ready_i) begin
      valid_q <= 1'b1;  // stalled so keep it
    end else if (ready_i) begin
      valid_q <= 1'b0;  // taken this cycle
    end
  end

  // captured response word, shown while valid_q is set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
    end else if (r_valid_i) begin
      data_q <= r_data_i;
    end
  end

  // controller stops requesting during a stall, so a held word is never overrun
  a_no_overrun: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_q |-> !r_valid_i
  ) else $error("response arrived while a held word was pending");

endmodule : source_resp_hold

`default_nettype wire

/* source_stream_merge.sv */
// joins the per-port words into one stream beat under a common valid/ready handshake
`timescale 1ns/10ps
`default_nettype none

module source_stream_merge (
  input  logic                              clk_i,          // assertion sampling only
  input  logic                              rst_ni,
  input  logic                              clear_i,        // a clear may drop a pending beat
  input  logic [tcdm_pkg::NB_PORTS-1:0]     port_valid_i,
  input  logic [streamer_pkg::STREAM_W-1:0] port_data_i,    // port i in word slice i
  input  logic                              stream_ready_i,
  output logic [tcdm_pkg::NB_PORTS-1:0]     port_ready_o,
  output logic                              stream_valid_o,
  output logic [streamer_pkg::STREAM_W-1:0] stream_data_o
);

  logic beat_hs; // beat accepted by the sink

  // beat complete only with a word on every port
  assign stream_valid_o = &port_valid_i;
  assign stream_data_o  = port_data_i;

  // ports release together, never a partial beat
  assign beat_hs      = stream_valid_o & stream_ready_i;
  assign port_ready_o = {tcdm_pkg::NB_PORTS{beat_hs}};

  // a stalled beat stays valid and unchanged until taken
  a_valid_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (stream_valid_o && !stream_ready_i && !clear_i) |=>
      (stream_valid_o && $stable(stream_data_o))
  ) else $error("stream beat dropped or changed before acceptance");

endmodule : source_stream_merge

`default_nettype wire

/* stream_source.sv */
// load streamer top, reads a 2-D pattern over parallel memory ports into one wide output stream
`timescale 1ns/10ps
`default_nettype none

module stream_source (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  // control
  input  logic                                              req_start_i,
  output logic                                              ready_start_o,
  output logic                                              done_o,
  input  logic [tcdm_pkg::ADDR_W-1:0]                       base_addr_i,
  input  logic [streamer_pkg::CNT_W-1:0]                    trans_size_i,
  input  logic [streamer_pkg::CNT_W-1:0]                    line_length_i,
  input  logic [streamer_pkg::CNT_W-1:0]                    line_stride_i,
  // memory ports, port i in slice i
  output logic [tcdm_pkg::NB_PORTS-1:0]                     tcdm_req_o,
  output logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::ADDR_W-1:0] tcdm_add_o,
  input  logic [tcdm_pkg::NB_PORTS-1:0]                     tcdm_gnt_i,
  input  logic [tcdm_pkg::NB_PORTS-1:0]                     tcdm_r_valid_i,
  input  logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::WORD_W-1:0] tcdm_r_data_i,
  // output stream
  output logic                                              stream_valid_o,
  output logic [streamer_pkg::STREAM_W-1:0]                 stream_data_o,
  input  logic                                              stream_ready_i
);

  logic                                               gen_en;
  logic                                               gen_clr;
  logic                                               in_progress;
  logic [tcdm_pkg::ADDR_W-1:0]                        gen_addr;    // beat address, port 0
  logic [tcdm_pkg::NB_PORTS-1:0]                      hold_valid;
  logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::WORD_W-1:0] hold_data;
  logic [tcdm_pkg::NB_PORTS-1:0]                      port_ready;

  source_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .req_start_i    ( req_start_i    ),
    .stream_ready_i ( stream_ready_i ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .in_progress_i  ( in_progress    ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .gen_en_o       ( gen_en         ),
    .gen_clr_o      ( gen_clr        ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         )
  );

  source_addressgen i_addressgen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( gen_clr       ), // host clear or end of transfer
    .enable_i      ( gen_en        ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .line_length_i ( line_length_i ),
    .line_stride_i ( line_stride_i ),
    .addr_o        ( gen_addr      ),
    .in_progress_o ( in_progress   )
  );

  for (genvar i = 0; i < tcdm_pkg::NB_PORTS; i++) begin : g_port
    // consecutive words of one beat
    assign tcdm_add_o[i] = gen_addr + (tcdm_pkg::ADDR_W)'(i * tcdm_pkg::WORD_BYTES);

    source_resp_hold i_hold (
      .clk_i     ( clk_i             ),
      .rst_ni    ( rst_ni            ),
      .clear_i   ( clear_i           ),
      .r_valid_i ( tcdm_r_valid_i[i] ),
      .r_data_i  ( tcdm_r_data_i[i]  ),
      .ready_i   ( port_ready[i]     ),
      .valid_o   ( hold_valid[i]     ),
      .data_o    ( hold_data[i]      )
    );
  end

  source_stream_merge i_merge (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .port_valid_i   ( hold_valid     ),
    .port_data_i    ( hold_data      ), // port 0 lands in the low word
    .stream_ready_i ( stream_ready_i ),
    .port_ready_o   ( port_ready     ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  )
  );

endmodule : stream_source

`default_nettype wire

/* tcdm_mem_model.sv */
// testbench data memory, grants all ports together with random stalls and answers one cycle later
`timescale 1ns/10ps
`default_nettype none

module tcdm_mem_model (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [7:0]                                          stall_rate_i, // percent
  input  logic [tcdm_pkg::NB_PORTS-1:0]                       tcdm_req_i,
  input  logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::ADDR_W-1:0] tcdm_add_i,
  output logic [tcdm_pkg::NB_PORTS-1:0]                       tcdm_gnt_o,
  output logic [tcdm_pkg::NB_PORTS-1:0]                       tcdm_r_valid_o,
  output logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::WORD_W-1:0] tcdm_r_data_o
);

  localparam logic [tcdm_pkg::WORD_W-1:0] MEM_PATTERN = 32'h5a5a0000;

  logic stall_q; // one stall decision for every port

  // contents are a function of the byte address
  function automatic logic [tcdm_pkg::WORD_W-1:0] word_at(
    input logic [tcdm_pkg::ADDR_W-1:0] addr
  );
    return addr ^ MEM_PATTERN;
  endfunction

  assign tcdm_gnt_o = {tcdm_pkg::NB_PORTS{~stall_q}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q        <= 1'b0;
      tcdm_r_valid_o <= '0;
      tcdm_r_data_o  <= '0;
    end else begin
      stall_q <= (($urandom % 100) < stall_rate_i); // next cycle's grant
      for (int i = 0; i < tcdm_pkg::NB_PORTS; i++) begin
        tcdm_r_valid_o[i] <= tcdm_req_i[i] & tcdm_gnt_o[i];
        if (tcdm_req_i[i] && tcdm_gnt_o[i]) begin
          tcdm_r_data_o[i] <= word_at(tcdm_add_i[i]); // answered next cycle
        end
      end
    end
  end

endmodule : tcdm_mem_model

`default_nettype wire

/* tb_stream_source.sv */
// top-level directed testbench driving the load streamer against the memory model
`timescale 1ns/10ps
`default_nettype none

module tb_stream_source;

  localparam logic [31:0] MEM_PATTERN     = 32'h5a5a0000;
  localparam int unsigned TOTAL_BEATS     = 8 + 12 + 40 + 16 + 16; // all transfers
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 10;

  logic clk;
  logic rst_n;
  logic clear;
  logic req_start;
  logic ready_start;
  logic done;
  logic [tcdm_pkg::ADDR_W-1:0]                          base_addr;
  logic [streamer_pkg::CNT_W-1:0]                       trans_size;
  logic [streamer_pkg::CNT_W-1:0]                       line_length;
  logic [streamer_pkg::CNT_W-1:0]                       line_stride;
  logic [tcdm_pkg::NB_PORTS-1:0]                        tcdm_req;
  logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::ADDR_W-1:0]  tcdm_add;
  logic [tcdm_pkg::NB_PORTS-1:0]                        tcdm_gnt;
  logic [tcdm_pkg::NB_PORTS-1:0]                        tcdm_r_valid;
  logic [tcdm_pkg::NB_PORTS-1:0][tcdm_pkg::WORD_W-1:0]  tcdm_r_data;
  logic                                                 stream_valid;
  logic [streamer_pkg::STREAM_W-1:0]                    stream_data;
  logic                                                 stream_ready;
  logic [7:0]                                           stall_rate;

  tcdm_mem_model i_mem (
    .clk_i (clk), .rst_ni (rst_n), .stall_rate_i (stall_rate),
    .tcdm_req_i (tcdm_req), .tcdm_add_i (tcdm_add), .tcdm_gnt_o (tcdm_gnt),
    .tcdm_r_valid_o (tcdm_r_valid), .tcdm_r_data_o (tcdm_r_data)
  );

  stream_source DUT (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear),
    .req_start_i (req_start), .ready_start_o (ready_start), .done_o (done),
    .base_addr_i (base_addr), .trans_size_i (trans_size),
    .line_length_i (line_length), .line_stride_i (line_stride),
    .tcdm_req_o (tcdm_req), .tcdm_add_o (tcdm_add), .tcdm_gnt_i (tcdm_gnt),
    .tcdm_r_valid_i (tcdm_r_valid), .tcdm_r_data_i (tcdm_r_data),
    .stream_valid_o (stream_valid), .stream_data_o (stream_data),
    .stream_ready_i (stream_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // hang guard sized from the total number of beats
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $fatal(1, "simulation stopped by watchdog");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string test_name,
                             input logic [streamer_pkg::STREAM_W-1:0] expected,
                             input logic [streamer_pkg::STREAM_W-1:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // byte address read by one port for beat k of the 2-D pattern
  function automatic logic [31:0] port_addr(input logic [31:0] base, input int unsigned k,
                                            input int unsigned ll, input int unsigned stride,
                                            input int unsigned port);
    return base + (k / ll) * stride + (k % ll) * streamer_pkg::STEP_BYTES
           + port * tcdm_pkg::WORD_BYTES;
  endfunction

  // beat k of the 2-D pattern with port 0 in the low word
  function automatic logic [streamer_pkg::STREAM_W-1:0] expected_beat(
    input logic [31:0] base, input int unsigned k,
    input int unsigned ll, input int unsigned stride);
    logic [streamer_pkg::STREAM_W-1:0] beat;
    for (int i = 0; i < tcdm_pkg::NB_PORTS; i++) begin
      beat[i*tcdm_pkg::WORD_W +: tcdm_pkg::WORD_W] =
        port_addr(base, k, ll, stride, i) ^ MEM_PATTERN;
    end
    return beat;
  endfunction

  // starts a transfer and checks every accepted request and beat until done
  task automatic run_transfer(input string name, input logic [31:0] base,
                              input int unsigned size, input int unsigned ll,
                              input int unsigned stride, input int unsigned stall,
                              input bit random_ready);
    int unsigned beat_cnt;
    int unsigned req_cnt;
    bit          done_seen;
    beat_cnt  = 0;
    req_cnt   = 0;
    done_seen = 1'b0;
    @(posedge clk);
    #2;
    base_addr    = base;
    trans_size   = size[streamer_pkg::CNT_W-1:0];
    line_length  = ll[streamer_pkg::CNT_W-1:0];
    line_stride  = stride[streamer_pkg::CNT_W-1:0];
    stall_rate   = stall[7:0];
    stream_ready = 1'b1;
    req_start    = 1'b1;
    @(posedge clk);
    #2;
    req_start = 1'b0;
    while (!(done_seen && beat_cnt == size)) begin
      @(negedge clk); // outputs settled before the handshake edge
      if (tcdm_req[0] && tcdm_gnt[0]) begin
        for (int i = 0; i < tcdm_pkg::NB_PORTS; i++) begin
          check_value(name, port_addr(base, req_cnt, ll, stride, i), tcdm_add[i]);
        end
        req_cnt++;
      end
      if (stream_valid && stream_ready) begin
        if (beat_cnt >= size) abort_run({name, ": beat received beyond the transfer size"});
        check_value(name, expected_beat(base, beat_cnt, ll, stride), stream_data);
        beat_cnt++;
      end
      if (done) begin
        if (done_seen) abort_run({name, ": done pulsed more than once"});
        // final beat shows up together with the pulse
        check_value(name, 1, stream_valid);
        check_value(name, expected_beat(base, size - 1, ll, stride), stream_data);
        done_seen = 1'b1;
      end
      @(posedge clk);
      #2;
      stream_ready = random_ready ? (($urandom % 100) < 70) : 1'b1;
    end
    @(negedge clk);
    check_value(name, 1, ready_start);  // back in idle
    check_value(name, 0, done);         // single-cycle pulse
    check_value(name, 0, stream_valid); // nothing beyond the last beat
    check_value(name, 0, tcdm_req);
    @(posedge clk);
    #2;
    stall_rate   = 8'd0;
    stream_ready = 1'b1;
  endtask

  task automatic verify_reset_state();
    @(negedge clk);
    check_value("after_reset", 1, ready_start);
    check_value("after_reset", 0, done);
    check_value("after_reset", 0, stream_valid);
    check_value("after_reset", 0, tcdm_req);
  endtask

  task automatic clear_during_transfer();
    @(posedge clk);
    #2;
    base_addr   = 32'h0000_6000;
    trans_size  = 16'd16;
    line_length = 16'd4;
    line_stride = 16'd40;
    req_start   = 1'b1;
    @(posedge clk);
    #2;
    req_start = 1'b0;
    repeat (5) @(posedge clk); // a few beats in flight
    #2;
    clear = 1'b1;
    @(posedge clk);
    #2;
    clear = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value("clear_midway", 1, ready_start);
      check_value("clear_midway", 0, tcdm_req);
      check_value("clear_midway", 0, stream_valid);
    end
    run_transfer("clear_then_full", 32'h0000_6000, 16, 4, 40, 0, 1'b0); // from beat 0
  endtask

  initial begin
    void'($urandom(32'ha1be3de1));
    rst_n        = 1'b0;
    clear        = 1'b0;
    req_start    = 1'b0;
    base_addr    = '0;
    trans_size   = '0;
    line_length  = '0;
    line_stride  = '0;
    stream_ready = 1'b1;
    stall_rate   = 8'd0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    verify_reset_state();
    run_transfer("linear", 32'h0000_1000, 8, 8, 0, 0, 1'b0);
    run_transfer("two_dim", 32'h0000_2000, 12, 3, 64, 0, 1'b0);
    run_transfer("random_stalls", 32'h0000_4100, 40, 5, 48, 30, 1'b1);
    clear_during_transfer();
    $display("** PASS **");
    $finish;
  end

endmodule : tb_stream_source

`default_nettype wire

/* all.f */
tcdm_pkg.sv
streamer_pkg.sv
source_addressgen.sv
source_ctrl.sv
source_resp_hold.sv
source_stream_merge.sv
stream_source.sv
tcdm_mem_model.sv
tb_stream_source.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load streamer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_stream_source \
  --Mdir obj_dir -o tb_stream_source
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_stream_source > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
